// File: list.f
+incdir+include
source/l2_pkg.sv
source/axi_pkg.sv
source/l2_arbiter.sv
source/l2_cache.sv
source/axi_burst_master.sv
source/performance_counters.sv
source/gpgpu_mem.sv
sim/gpgpu_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the gpgpu_mem testbench with Verilator.
# The run passes only if the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module gpgpu_mem_tb -f list.f -o gpgpu_mem_sim \
	&& ./obj_dir/gpgpu_mem_sim | tee /dev/stderr | grep -qx "No errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: sim/gpgpu_mem_tb.sv
/*
 * Testbench for gpgpu_mem. Two cores send random loads and stores, an AXI
 * memory with random back-pressure answers the bursts, and a shadow model
 * of the L2 predicts every response, burst and counter value.
 */

`timescale 1ns/1ps

`include "gpgpu_consts.svh"

module gpgpu_mem_tb;

	import l2_pkg::*;
	import axi_pkg::*;

	localparam int TIMEOUT = 2000; // Cycles allowed for any single wait
	localparam int TAG_BITS = 24;
	localparam logic [31:0] BASE = 32'h4000_0000;

	logic reset; // Clock
	logic clk; // Asynchronous reset, active high
	logic core_req_valid [`NUM_CORES];
	l2_req_t core_req [`NUM_CORES];
	logic core_req_ready [`NUM_CORES];
	logic rsp_valid;
	l2_rsp_t rsp;
	axi_aw_t axi_aw;
	logic awvalid;
	logic awready;
	axi_w_t axi_w;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	axi_ar_t axi_ar;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	perf_counts_t counts;

	integer seed;
	int errors;
	int checks;
	int cycle;
	logic hung; // Set once any wait has timed out

	// Shadow copy of the cache
	logic m_valid [`NUM_SETS];
	logic m_dirty [`NUM_SETS];
	logic [TAG_BITS-1:0] m_tag [`NUM_SETS];
	axi_line_t m_line [`NUM_SETS];
	logic [31:0] m_mem [logic [31:0]]; // Memory as the model sees it
	logic [`CORE_INDEX_WIDTH-1:0] m_last_core;
	int m_hits;
	int m_misses;
	int m_wbs;
	int m_stores;

	// Expected traffic in order
	l2_rsp_t exp_rsp [$];
	logic exp_hit [$];
	int exp_cycle [$];
	axi_aw_t exp_aw [$];
	axi_line_t exp_wb [$];
	axi_ar_t exp_ar [$];

	logic [31:0] mem_arr [logic [31:0]]; // Responder storage

	gpgpu_mem gpgpu_mem_inst (
		.reset(reset),
		.clk(clk),
		.core_req_valid(core_req_valid),
		.core_req(core_req),
		.core_req_ready(core_req_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.axi_aw(axi_aw),
		.awvalid(awvalid),
		.awready(awready),
		.axi_w(axi_w),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.axi_ar(axi_ar),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.counts(counts)
	);

	initial
	begin
		reset = 1'b0;
		forever #4 reset = ~reset; // 8 ns period
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// Untouched memory holds its address with the halves exchanged
	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [31:0] model_read(input logic [31:0] addr);
		if (m_mem.exists(addr))
			return m_mem[addr];
		return init_word(addr);
	endfunction

	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		if (mem_arr.exists(addr))
			return mem_arr[addr];
		return init_word(addr);
	endfunction

	// Only four tags share the sets so that lines conflict often
	function automatic logic [31:0] rand_addr();
		logic [31:0] r;
		r = rand32();
		return BASE | {22'd0, r[9:2], 2'b00};
	endfunction

	function automatic logic [`CORE_INDEX_WIDTH-1:0] rand_core();
		logic [31:0] r;
		r = rand32();
		return r[`CORE_INDEX_WIDTH-1:0];
	endfunction

	function automatic l2_op_t rand_op();
		logic [31:0] r;
		r = rand32();
		return r[0] ? L2_STORE : L2_LOAD;
	endfunction

	function automatic l2_req_t make_req(input l2_op_t op, input logic [31:0] addr);
		l2_req_t req;
		logic [31:0] r;
		r = rand32();
		req.op = op;
		req.strand = r[`STRAND_INDEX_WIDTH-1:0];
		req.addr = addr;
		req.data = rand32();
		req.mask = r[7:4];
		return req;
	endfunction

	task automatic check_rsp(input l2_rsp_t got, input l2_rsp_t want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: rsp core %0d strand %0d op %0d addr %h data %h",
				$time, got.core, got.strand, got.op, got.addr, got.data);
			$display("  expected core %0d strand %0d op %0d addr %h data %h",
				want.core, want.strand, want.op, want.addr, want.data);
		end
	endtask

	task automatic check_counts(input perf_counts_t got, input perf_counts_t want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: counts hit %0d miss %0d wb %0d store %0d", $time,
				got.hit, got.miss, got.writeback, got.store);
			$display("  expected hit %0d miss %0d wb %0d store %0d",
				want.hit, want.miss, want.writeback, want.store);
		end
	endtask

	task automatic check_aw(input axi_aw_t got, input axi_aw_t want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: AW addr %h len %0d, expected addr %h len %0d",
				$time, got.addr, got.len, want.addr, want.len);
		end
	endtask

	task automatic check_ar(input axi_ar_t got, input axi_ar_t want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: AR addr %h len %0d, expected addr %h len %0d",
				$time, got.addr, got.len, want.addr, want.len);
		end
	endtask

	task automatic check_w(input axi_w_t got, input axi_w_t want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: W data %h last %0d, expected data %h last %0d",
				$time, got.data, got.last, want.data, want.last);
		end
	endtask

	task automatic check_core(input logic [`CORE_INDEX_WIDTH-1:0] got,
		input logic [`CORE_INDEX_WIDTH-1:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: core %0d granted, expected core %0d",
				$time, got, want);
		end
	endtask

	// Applies one accepted request to the model and queues what must follow
	task automatic note_accept(input logic [`CORE_INDEX_WIDTH-1:0] core, input l2_req_t req);
		logic [3:0] set;
		logic [TAG_BITS-1:0] tag;
		logic [1:0] word;
		logic hit;
		logic [`CORE_INDEX_WIDTH-1:0] want_core;
		logic [31:0] new_word;
		axi_aw_t aw;
		axi_ar_t ar;
		l2_rsp_t r;

		if (core_req_valid[0] && core_req_valid[1])
			want_core = ~m_last_core; // Round robin under contention
		else
			want_core = core_req_valid[1];
		check_core(core, want_core);
		m_last_core = want_core;

		set = req.addr[7:4];
		tag = req.addr[31:8];
		word = req.addr[3:2];
		hit = m_valid[set] && (m_tag[set] == tag);
		if (hit)
			m_hits++;
		else
		begin
			m_misses++;
			if (m_valid[set] && m_dirty[set])
			begin
				m_wbs++;
				aw.addr = {m_tag[set], set, 4'h0};
				aw.len = 8'd3;
				exp_aw.push_back(aw);
				exp_wb.push_back(m_line[set]);
				for (int w = 0; w < `LINE_WORDS; w++)
					m_mem[{aw.addr[31:4], w[1:0], 2'b00}] = m_line[set][w];
			end
			ar.addr = {req.addr[31:4], 4'h0};
			ar.len = 8'd3;
			exp_ar.push_back(ar);
			for (int w = 0; w < `LINE_WORDS; w++)
				m_line[set][w] = model_read({req.addr[31:4], w[1:0], 2'b00});
			m_valid[set] = 1'b1;
			m_dirty[set] = 1'b0;
			m_tag[set] = tag;
		end

		new_word = m_line[set][word];
		if (req.op == L2_STORE)
		begin
			for (int b = 0; b < 4; b++)
				if (req.mask[b])
					new_word[8 * b +: 8] = req.data[8 * b +: 8];
			m_line[set][word] = new_word;
			m_dirty[set] = 1'b1;
			m_stores++;
		end

		r.core = core;
		r.strand = req.strand;
		r.op = req.op;
		r.addr = req.addr;
		r.data = new_word;
		exp_rsp.push_back(r);
		exp_hit.push_back(hit);
		exp_cycle.push_back(cycle);
	endtask

	task automatic take_rsp();
		l2_rsp_t want;
		logic was_hit;
		int t0;

		if (exp_rsp.size() == 0)
		begin
			errors++;
			$display("Response at %0t arrived with no request outstanding", $time);
			return;
		end
		want = exp_rsp.pop_front();
		was_hit = exp_hit.pop_front();
		t0 = exp_cycle.pop_front();
		check_rsp(rsp, want);
		if (was_hit)
		begin
			checks++;
			if (cycle - t0 != 2)
			begin
				errors++;
				$display("CHECK FAILED at %0t: hit answered %0d cycles after acceptance, expected 2",
					$time, cycle - t0);
			end
		end
	endtask

	// Acceptance and response monitor
	initial
	begin
		cycle = 0;
		m_last_core = 1'b1; // Core 0 wins first after reset
		m_hits = 0;
		m_misses = 0;
		m_wbs = 0;
		m_stores = 0;
		for (int s = 0; s < `NUM_SETS; s++)
		begin
			m_valid[s] = 1'b0;
			m_dirty[s] = 1'b0;
			m_tag[s] = '0;
			m_line[s] = '0;
		end
		forever
		begin
			@(posedge reset);
			if (!clk)
			begin
				if (core_req_valid[0] && core_req_ready[0])
					note_accept(1'b0, core_req[0]);
				if (core_req_valid[1] && core_req_ready[1])
					note_accept(1'b1, core_req[1]);
				if (rsp_valid)
					take_rsp();
				cycle++;
			end
		end
	end

	// AXI memory that observes handshakes on the rising edge and drives on the falling one
	initial
	begin
		logic [31:0] r;
		logic [31:0] wr_addr;
		logic [31:0] rd_addr;
		int wr_beat;
		int rd_beat;
		logic b_pending;
		logic r_active;
		axi_line_t wb_line;
		axi_w_t want_w;

		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		wr_addr = '0;
		rd_addr = '0;
		wr_beat = 0;
		rd_beat = 0;
		b_pending = 1'b0;
		r_active = 1'b0;
		wb_line = '0;
		forever
		begin
			@(posedge reset);
			if (awvalid && awready)
			begin
				if (exp_aw.size() == 0)
				begin
					errors++;
					$display("Write burst at %0t while no dirty victim was due", $time);
				end
				else
				begin
					check_aw(axi_aw, exp_aw.pop_front());
					wb_line = exp_wb.pop_front();
				end
				wr_addr = axi_aw.addr;
				wr_beat = 0;
			end
			if (wvalid && wready)
			begin
				want_w.data = wb_line[wr_beat[1:0]];
				want_w.last = (wr_beat == `LINE_WORDS - 1);
				check_w(axi_w, want_w);
				mem_arr[{wr_addr[31:4], wr_beat[1:0], 2'b00}] = axi_w.data;
				wr_beat++;
				if (wr_beat == `LINE_WORDS)
					b_pending = 1'b1;
			end
			if (bvalid && bready)
				b_pending = 1'b0;
			if (arvalid && arready)
			begin
				if (exp_ar.size() == 0)
				begin
					errors++;
					$display("Read burst at %0t while no miss was due", $time);
				end
				else
					check_ar(axi_ar, exp_ar.pop_front());
				rd_addr = axi_ar.addr;
				rd_beat = 0;
				r_active = 1'b1;
			end
			if (rvalid && rready)
			begin
				rd_beat++;
				if (rd_beat == `LINE_WORDS)
					r_active = 1'b0;
			end

			@(negedge reset);
			r = rand32();
			awready = (r[1:0] != 2'd0);
			wready = (r[3:2] != 2'd0);
			arready = (r[5:4] != 2'd0);
			bvalid = b_pending && (bvalid || r[7:6] != 2'd0); // Held until taken
			rvalid = r_active && (r[9:8] != 2'd0);
			rdata = mem_read({rd_addr[31:4], rd_beat[1:0], 2'b00});
		end
	end

	// Holds the request until the port is ready and leaves valid up
	task automatic send_req(input logic [`CORE_INDEX_WIDTH-1:0] core, input l2_req_t req);
		int n;
		if (hung)
			return;
		@(negedge reset);
		core_req_valid[core] = 1'b1;
		core_req[core] = req;
		n = 0;
		@(posedge reset);
		while (!core_req_ready[core] && n < TIMEOUT)
		begin
			@(posedge reset);
			n++;
		end
		if (!core_req_ready[core])
		begin
			hung = 1'b1;
			errors++;
			$display("Timeout at %0t: core %0d request was never accepted", $time, core);
		end
	endtask

	task automatic drop_req(input logic [`CORE_INDEX_WIDTH-1:0] core);
		@(negedge reset);
		core_req_valid[core] = 1'b0;
	endtask

	task automatic issue(input logic [`CORE_INDEX_WIDTH-1:0] core, input l2_req_t req);
		logic [31:0] r;
		r = rand32();
		send_req(core, req);
		drop_req(core);
		repeat (r[1:0]) @(negedge reset); // Gap of 0 to 3 cycles
	endtask

	task automatic stream(input logic [`CORE_INDEX_WIDTH-1:0] core, input int count);
		for (int i = 0; i < count; i++)
			send_req(core, make_req(rand_op(), rand_addr()));
		drop_req(core);
	endtask

	task automatic wait_idle();
		int n;
		if (hung)
			return;
		n = 0;
		while (exp_rsp.size() != 0 && n < TIMEOUT)
		begin
			@(negedge reset);
			n++;
		end
		if (exp_rsp.size() != 0)
		begin
			hung = 1'b1;
			errors++;
			$display("Timeout at %0t: %0d responses never arrived", $time, exp_rsp.size());
		end
		@(negedge reset); // Counters catch up
	endtask

	task automatic end_test(input int num, input string name, input int err0);
		$display("test %0d %s: %0d failures", num, name, errors - err0);
	endtask

	initial
	begin
		int err0;
		logic [31:0] addr;
		perf_counts_t want;

		seed = 32'h5f3a1e09;
		errors = 0;
		checks = 0;
		hung = 1'b0;
		clk = 1'b1;
		for (int i = 0; i < `NUM_CORES; i++)
		begin
			core_req_valid[i] = 1'b0;
			core_req[i] = '0;
		end
		repeat (8) @(posedge reset);
		@(negedge reset);
		clk = 1'b0;

		err0 = errors;
		for (int i = 0; i < 16; i++)
			issue(rand_core(), make_req(L2_LOAD, rand_addr()));
		wait_idle();
		end_test(1, "cold loads", err0);

		err0 = errors;
		for (int i = 0; i < 16; i++)
		begin
			addr = rand_addr();
			issue(rand_core(), make_req(L2_STORE, addr));
			issue(rand_core(), make_req(L2_LOAD, addr));
		end
		wait_idle();
		end_test(2, "store then load", err0);

		err0 = errors;
		for (int i = 0; i < 6; i++)
		begin
			addr = rand_addr();
			issue(rand_core(), make_req(L2_STORE, addr));
			issue(rand_core(), make_req(L2_STORE, addr ^ 32'h0000_0100)); // Same set
			issue(rand_core(), make_req(L2_LOAD, addr));
		end
		wait_idle();
		end_test(3, "dirty eviction", err0);

		err0 = errors;
		fork
			stream(1'b0, 10);
			stream(1'b1, 10);
		join
		wait_idle();
		end_test(4, "round robin", err0);

		err0 = errors;
		for (int i = 0; i < 60; i++)
			issue(rand_core(), make_req(rand_op(), rand_addr()));
		wait_idle();
		end_test(5, "random mix", err0);

		err0 = errors;
		want.hit = `PC_WIDTH'(m_hits);
		want.miss = `PC_WIDTH'(m_misses);
		want.writeback = `PC_WIDTH'(m_wbs);
		want.store = `PC_WIDTH'(m_stores);
		check_counts(counts, want);
		if (exp_aw.size() != 0)
		begin
			errors++;
			$display("%0d expected write bursts never appeared", exp_aw.size());
		end
		if (exp_ar.size() != 0)
		begin
			errors++;
			$display("%0d expected read bursts never appeared", exp_ar.size());
		end
		end_test(6, "event counts", err0);

		$display("checks %0d, failures %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: source/gpgpu_mem.sv
/*
 * Shared memory side of the GPGPU: core arbiter, L2 cache, AXI burst
 * master and performance counters. Port reset carries the clock and
 * port clk the asynchronous active-high reset.
 */

`timescale 1ns/1ps

`include "gpgpu_consts.svh"

module gpgpu_mem (
	input logic reset,
	input logic clk,
	input logic core_req_valid [`NUM_CORES],
	input l2_pkg::l2_req_t core_req [`NUM_CORES],
	output logic core_req_ready [`NUM_CORES],
	output logic rsp_valid,
	output l2_pkg::l2_rsp_t rsp,
	output axi_pkg::axi_aw_t axi_aw,
	output logic awvalid,
	input logic awready,
	output axi_pkg::axi_w_t axi_w,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready,
	output axi_pkg::axi_ar_t axi_ar,
	output logic arvalid,
	input logic arready,
	input logic rvalid,
	output logic rready,
	input logic [31:0] rdata,
	output l2_pkg::perf_counts_t counts
);

	import l2_pkg::*;
	import axi_pkg::*;

	logic arb_valid;
	logic [`CORE_INDEX_WIDTH-1:0] arb_core;
	l2_req_t arb_req;
	logic arb_ready;
	logic mem_cmd_valid;
	mem_cmd_t mem_cmd;
	logic mem_done;
	axi_line_t fill_line;
	l2_event_t events;

	l2_arbiter l2_arbiter_inst (
		.reset(reset),
		.clk(clk),
		.core_req_valid(core_req_valid),
		.core_req(core_req),
		.core_req_ready(core_req_ready),
		.arb_valid(arb_valid),
		.arb_core(arb_core),
		.arb_req(arb_req),
		.arb_ready(arb_ready)
	);

	l2_cache l2_cache_inst (
		.reset(reset),
		.clk(clk),
		.arb_valid(arb_valid),
		.arb_core(arb_core),
		.arb_req(arb_req),
		.arb_ready(arb_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.mem_cmd_valid(mem_cmd_valid),
		.mem_cmd(mem_cmd),
		.mem_done(mem_done),
		.fill_line(fill_line),
		.events(events)
	);

	axi_burst_master axi_burst_master_inst (
		.reset(reset),
		.clk(clk),
		.mem_cmd_valid(mem_cmd_valid),
		.mem_cmd(mem_cmd),
		.mem_done(mem_done),
		.fill_line(fill_line),
		.axi_aw(axi_aw),
		.awvalid(awvalid),
		.awready(awready),
		.axi_w(axi_w),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.axi_ar(axi_ar),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata)
	);

	performance_counters performance_counters_inst (
		.reset(reset),
		.clk(clk),
		.events(events),
		.counts(counts)
	);

endmodule

// File: source/performance_counters.sv
/*
 * Saturating event counters for the L2. Each counter steps on the edge
 * after its event pulse and holds at its maximum.
 */

`timescale 1ns/1ps

`include "gpgpu_consts.svh"

module performance_counters (
	input logic reset,
	input logic clk,
	input l2_pkg::l2_event_t events,
	output l2_pkg::perf_counts_t counts
);

	function automatic logic [`PC_WIDTH-1:0] sat_inc(input logic [`PC_WIDTH-1:0] value,
		input logic pulse);
		if (pulse && value != '1)
			return value + 1'b1;
		return value; // Saturated or idle
	endfunction

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			counts <= '0;
		else
		begin
			counts.hit <= sat_inc(counts.hit, events.hit);
			counts.miss <= sat_inc(counts.miss, events.miss);
			counts.writeback <= sat_inc(counts.writeback, events.writeback);
			counts.store <= sat_inc(counts.store, events.store);
		end
	end

endmodule

// File: source/axi_burst_master.sv
/*
 * Runs line commands from the L2 as AXI4 incrementing bursts: an optional
 * writeback (AW, W beats, B) followed by the fill (AR, R beats).
 * mem_done pulses once the whole command has finished.
 */

`timescale 1ns/1ps

`include "gpgpu_consts.svh"

module axi_burst_master (
	input logic reset,
	input logic clk,
	input logic mem_cmd_valid,
	input axi_pkg::mem_cmd_t mem_cmd,
	output logic mem_done,
	output axi_pkg::axi_line_t fill_line,
	output axi_pkg::axi_aw_t axi_aw,
	output logic awvalid,
	input logic awready,
	output axi_pkg::axi_w_t axi_w,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready,
	output axi_pkg::axi_ar_t axi_ar,
	output logic arvalid,
	input logic arready,
	input logic rvalid,
	output logic rready,
	input logic [31:0] rdata
);

	localparam int BEAT_BITS = $clog2(`LINE_WORDS);
	localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(`LINE_WORDS - 1);

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_AW,
		S_W,
		S_B,
		S_AR,
		S_R,
		S_DONE
	} state_t;

	state_t state;
	logic [BEAT_BITS-1:0] beat;

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			state <= S_IDLE;
			beat <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					beat <= '0;
					if (mem_cmd_valid)
					begin
						if (mem_cmd.writeback)
							state <= S_AW;
						else if (mem_cmd.fill)
							state <= S_AR;
						else
							state <= S_DONE;
					end
				end
				S_AW:
				begin
					if (awready)
						state <= S_W;
				end
				S_W:
				begin
					if (wready)
					begin
						beat <= beat + 1'b1;
						if (beat == LAST_BEAT)
							state <= S_B;
					end
				end
				S_B:
				begin
					if (bvalid)
						state <= mem_cmd.fill ? S_AR : S_DONE;
				end
				S_AR:
				begin
					beat <= '0;
					if (arready)
						state <= S_R;
				end
				S_R:
				begin
					if (rvalid)
					begin
						beat <= beat + 1'b1;
						if (beat == LAST_BEAT)
							state <= S_DONE;
					end
				end
				default:
				begin
					state <= S_IDLE; // S_DONE lasts one cycle
				end
			endcase
		end
	end

	// Assemble the fill line beat by beat
	always_ff @(posedge reset)
	begin
		if (state == S_R && rvalid)
			fill_line[beat] <= rdata;
	end

	assign axi_aw.addr = mem_cmd.victim_addr;
	assign axi_aw.len = 8'(`LINE_WORDS - 1);
	assign awvalid = (state == S_AW);

	assign axi_w.data = mem_cmd.victim_data[beat];
	assign axi_w.last = (beat == LAST_BEAT);
	assign wvalid = (state == S_W);

	assign bready = (state == S_B);

	assign axi_ar.addr = mem_cmd.fill_addr;
	assign axi_ar.len = 8'(`LINE_WORDS - 1);
	assign arvalid = (state == S_AR);

	assign rready = (state == S_R);
	assign mem_done = (state == S_DONE);

endmodule

// File: source/l2_cache.sv
/*
 * Direct-mapped, write-back, write-allocate L2 cache serving one request
 * at a time. Misses go to the burst master as a fill, preceded by a
 * writeback when the victim is dirty. Responses are broadcast to all cores.
 */

`timescale 1ns/1ps

`include "gpgpu_consts.svh"

module l2_cache (
	input logic reset,
	input logic clk,
	input logic arb_valid,
	input logic [`CORE_INDEX_WIDTH-1:0] arb_core,
	input l2_pkg::l2_req_t arb_req,
	output logic arb_ready,
	output logic rsp_valid,
	output l2_pkg::l2_rsp_t rsp,
	output logic mem_cmd_valid,
	output axi_pkg::mem_cmd_t mem_cmd,
	input logic mem_done,
	input axi_pkg::axi_line_t fill_line,
	output l2_pkg::l2_event_t events
);

	import l2_pkg::*;
	import axi_pkg::*;

	localparam int WORD_BITS = $clog2(`LINE_WORDS);
	localparam int OFFSET_BITS = WORD_BITS + 2;
	localparam int SET_BITS = $clog2(`NUM_SETS);
	localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_LOOKUP,
		S_MEM_WAIT,
		S_UPDATE,
		S_RESPOND
	} state_t;

	state_t state;

	logic [`NUM_SETS-1:0] valid_bits;
	logic [`NUM_SETS-1:0] dirty_bits;
	logic [TAG_BITS-1:0] tag_array [`NUM_SETS];
	axi_line_t data_array [`NUM_SETS];

	l2_req_t req_q; // Request being served
	logic [`CORE_INDEX_WIDTH-1:0] core_q;
	axi_line_t line_q; // Fill data until the update cycle

	logic [SET_BITS-1:0] req_set;
	logic [TAG_BITS-1:0] req_tag;
	logic [WORD_BITS-1:0] req_word;
	logic hit;
	logic victim_dirty;
	logic is_store;
	logic [31:0] cur_word;
	logic [31:0] merged_word;

	assign req_set = req_q.addr[OFFSET_BITS +: SET_BITS];
	assign req_tag = req_q.addr[31 -: TAG_BITS];
	assign req_word = req_q.addr[2 +: WORD_BITS];
	assign hit = valid_bits[req_set] && (tag_array[req_set] == req_tag);
	assign victim_dirty = valid_bits[req_set] && dirty_bits[req_set];
	assign is_store = (req_q.op == L2_STORE);
	assign cur_word = data_array[req_set][req_word];

	// Byte merge of store data into the addressed word
	always_comb
	begin
		for (int b = 0; b < 4; b++)
		begin
			if (req_q.mask[b])
				merged_word[8 * b +: 8] = req_q.data[8 * b +: 8];
			else
				merged_word[8 * b +: 8] = cur_word[8 * b +: 8];
		end
	end

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			state <= S_IDLE;
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (arb_valid)
						state <= S_LOOKUP;
				end
				S_LOOKUP:
				begin
					state <= hit ? S_RESPOND : S_MEM_WAIT;
				end
				S_MEM_WAIT:
				begin
					if (mem_done)
						state <= S_UPDATE;
				end
				S_UPDATE:
				begin
					state <= S_RESPOND;
					valid_bits[req_set] <= 1'b1;
					dirty_bits[req_set] <= 1'b0; // Fresh copy of memory
				end
				S_RESPOND:
				begin
					state <= S_IDLE;
					if (is_store)
						dirty_bits[req_set] <= 1'b1;
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge reset)
	begin
		if (state == S_IDLE && arb_valid)
		begin
			req_q <= arb_req;
			core_q <= arb_core;
		end

		if (state == S_LOOKUP)
		begin
			mem_cmd.fill <= 1'b1; // Every miss allocates
			mem_cmd.writeback <= victim_dirty;
			mem_cmd.fill_addr <= {req_q.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
			mem_cmd.victim_addr <= {tag_array[req_set], req_set, {OFFSET_BITS{1'b0}}};
			mem_cmd.victim_data <= data_array[req_set];
		end

		if (state == S_MEM_WAIT && mem_done)
			line_q <= fill_line;

		if (state == S_UPDATE)
		begin
			tag_array[req_set] <= req_tag;
			data_array[req_set] <= line_q;
		end

		if (state == S_RESPOND && is_store)
			data_array[req_set][req_word] <= merged_word; // Store lands with its response
	end

	assign arb_ready = (state == S_IDLE);
	assign mem_cmd_valid = (state == S_MEM_WAIT);
	assign rsp_valid = (state == S_RESPOND);

	assign rsp.core = core_q;
	assign rsp.strand = req_q.strand;
	assign rsp.op = req_q.op;
	assign rsp.addr = req_q.addr;
	assign rsp.data = is_store ? merged_word : cur_word;

	assign events.hit = (state == S_LOOKUP) && hit;
	assign events.miss = (state == S_LOOKUP) && !hit;
	assign events.writeback = (state == S_LOOKUP) && !hit && victim_dirty;
	assign events.store = (state == S_RESPOND) && is_store;

endmodule

// File: source/l2_arbiter.sv
/*
 * Round-robin arbiter between the two core request ports and the L2.
 * Selection is combinational; only the last-grant bit is registered.
 */

`timescale 1ns/1ps

`include "gpgpu_consts.svh"

module l2_arbiter (
	input logic reset,
	input logic clk,
	input logic core_req_valid [`NUM_CORES],
	input l2_pkg::l2_req_t core_req [`NUM_CORES],
	output logic core_req_ready [`NUM_CORES],
	output logic arb_valid,
	output logic [`CORE_INDEX_WIDTH-1:0] arb_core,
	output l2_pkg::l2_req_t arb_req,
	input logic arb_ready
);

	logic last_grant; // Core that won the previous transfer
	logic sel;

	always_comb
	begin
		if (core_req_valid[0] && core_req_valid[1])
			sel = ~last_grant; // Contention goes to the other core
		else
			sel = core_req_valid[1];
	end

	assign arb_valid = core_req_valid[0] || core_req_valid[1];
	assign arb_core = sel;
	assign arb_req = core_req[sel];

	// Only the granted core sees ready
	assign core_req_ready[0] = arb_ready && !sel;
	assign core_req_ready[1] = arb_ready && sel;

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			last_grant <= 1'b1; // Core 0 first after reset
		else if (arb_valid && arb_ready)
			last_grant <= sel;
	end

endmodule

// File: source/axi_pkg.sv
/*
 * AXI4 burst channel structs and the line command passed from the L2
 * cache to the burst master.
 */

`include "gpgpu_consts.svh"

package axi_pkg;

	typedef logic [`LINE_WORDS-1:0][31:0] axi_line_t; // Word 0 at the lowest address

	typedef struct packed
	{
		logic [31:0] addr;
		logic [7:0] len;
	} axi_aw_t;

	typedef struct packed
	{
		logic [31:0] addr;
		logic [7:0] len;
	} axi_ar_t;

	typedef struct packed
	{
		logic [31:0] data;
		logic last;
	} axi_w_t;

	typedef struct packed
	{
		logic fill;
		logic writeback; // Victim goes out before the fill
		logic [31:0] fill_addr; // Line aligned
		logic [31:0] victim_addr; // Line aligned
		axi_line_t victim_data;
	} mem_cmd_t;

endpackage

// File: source/l2_pkg.sv
/*
 * L2 request, response and event types shared by the arbiter, the cache,
 * the performance counters and the top level.
 */

`include "gpgpu_consts.svh"

package l2_pkg;

	typedef enum logic
	{
		L2_LOAD = 1'b0,
		L2_STORE = 1'b1
	} l2_op_t;

	typedef struct packed
	{
		l2_op_t op;
		logic [`STRAND_INDEX_WIDTH-1:0] strand;
		logic [31:0] addr; // Byte address, word aligned
		logic [31:0] data;
		logic [3:0] mask; // Byte enables for stores
	} l2_req_t;

	typedef struct packed
	{
		logic [`CORE_INDEX_WIDTH-1:0] core; // Cores filter the broadcast on this
		logic [`STRAND_INDEX_WIDTH-1:0] strand;
		l2_op_t op;
		logic [31:0] addr;
		logic [31:0] data;
	} l2_rsp_t;

	typedef struct packed
	{
		logic hit;
		logic miss;
		logic writeback;
		logic store;
	} l2_event_t;

	typedef struct packed
	{
		logic [`PC_WIDTH-1:0] hit;
		logic [`PC_WIDTH-1:0] miss;
		logic [`PC_WIDTH-1:0] writeback;
		logic [`PC_WIDTH-1:0] store;
	} perf_counts_t;

endpackage

// File: include/gpgpu_consts.svh
/*
 * Build-wide constants for the shared memory side of the GPGPU.
 * Included by the packages and by every module that sizes ports or arrays.
 */

`ifndef GPGPU_CONSTS_SVH
`define GPGPU_CONSTS_SVH

`define NUM_CORES 2 // Request ports into the L2
`define CORE_INDEX_WIDTH 1
`define STRAND_INDEX_WIDTH 2

`define LINE_WORDS 4 // 32-bit words per line
`define NUM_SETS 16 // Direct mapped, one line per set

`define PC_WIDTH 16 // Performance counter width

`endif
